// File: sources.f
+incdir+dv
hw/follow_pkg.sv
hw/tracker_regs.sv
hw/object_locator.sv
hw/motor_speed_ctrl.sv
hw/follow_top.sv
dv/follow_tb.sv

// File: dv/follow_tests.svh
// expected proximity from the total hit count
function automatic logic [2:0] model_prox(input int total);
  int d;
  int step;
  logic [1:0] mag;
  step = sh_area_step;
  d = (total > sh_area_target) ? total - sh_area_target : sh_area_target - total;
  if (d >= 3 * step) mag = 2'd3;
  else if (d >= 2 * step) mag = 2'd2;
  else if (d >= step) mag = 2'd1;
  else mag = 2'd0;
  return {(total > sh_area_target), mag};
endfunction

// wheel speeds from the stored centroid
task automatic model_speeds(input logic lost_exp);
  logic signed [15:0] v;
  v = '0;
  exp_left = '0;
  exp_rght = '0;
  if (!sh_enable || lost_exp || exp_cent == 8'h0) begin
    v = '0;
  end else if (exp_cent[3] && exp_cent[4]) begin
    v = (exp_prox[1:0] == 2'd0) ? 16'sd0 : sh_vel[exp_prox[1:0]];
    if (exp_prox[2]) v = -v;  // back off
    exp_left = v;
    exp_rght = v;
  end else if (exp_cent[3:0] != 4'h0) begin
    for (int b = 0; b < 4; b++) if (exp_cent[b]) v = sh_vel[3 - b];
    exp_rght = v;
  end else begin
    for (int b = 7; b >= 4; b--) if (exp_cent[b]) v = sh_vel[b - 4];
    exp_left = v;
  end
endtask

task automatic wait_speeds();
  int n;
  n = 0;
  @(negedge clk);
  while ((motor_dps_left !== exp_left || motor_dps_rght !== exp_rght) && n < 20) begin
    @(negedge clk);
    n++;
  end
  check("motor_dps_left", {16'h0, motor_dps_left}, {16'h0, exp_left});
  check("motor_dps_rght", {16'h0, motor_dps_rght}, {16'h0, exp_rght});
endtask

// one frame of zone_hits, then status and speeds
task automatic frame_and_check(input logic lost_exp);
  int total;
  int n;
  logic [7:0] mask;
  logic [2:0] prox;
  logic [31:0] status;
  logic [31:0] exp_status;
  total = 0;
  for (int i = 0; i < 8; i++) begin
    total += zone_hits[i];
    mask[i] = (zone_hits[i] >= sh_zone_min);
  end
  prox = model_prox(total);
  if (mask != 8'h0) begin
    exp_cent = mask;
    exp_prox = prox;
  end
  model_speeds(lost_exp);
  exp_status = {15'h0, lost_exp, 5'h0, prox, mask};
  send_frame();
  n = 0;
  read_reg(follow_pkg::reg_status, status);
  while (status !== exp_status && n < 20) begin
    read_reg(follow_pkg::reg_status, status);
    n++;
  end
  check("reg_status", status, exp_status);
  wait_speeds();
endtask

task automatic check_reg(input follow_pkg::cfg_addr_t a, input logic [31:0] exp);
  logic [31:0] d;
  read_reg(a, d);
  check("cfg_rdata", d, exp);
endtask

task automatic reset_values();
  check("motor_dps_left", {16'h0, motor_dps_left}, 32'h0);
  check("motor_dps_rght", {16'h0, motor_dps_rght}, 32'h0);
  check_reg(follow_pkg::reg_ctrl, 32'd0);
  check_reg(follow_pkg::reg_zone_min, 32'd4);
  check_reg(follow_pkg::reg_area_target, 32'd400);
  check_reg(follow_pkg::reg_area_step, 32'd100);
  check_reg(follow_pkg::reg_vel0, 32'd25);
  check_reg(follow_pkg::reg_vel1, 32'd50);
  check_reg(follow_pkg::reg_vel2, 32'd100);
  check_reg(follow_pkg::reg_vel3, 32'd200);
  check_reg(follow_pkg::reg_lost_limit, 32'h4000_0000);
  check_reg(follow_pkg::reg_status, 32'h0);
  write_reg(follow_pkg::reg_lost_limit, 32'h1234_5678);
  check_reg(follow_pkg::reg_lost_limit, 32'h1234_5678);
  write_reg(follow_pkg::reg_lost_limit, 32'h4000_0000);
  write_reg(follow_pkg::reg_zone_min, 32'd7);
  check_reg(follow_pkg::reg_zone_min, 32'd7);
  write_reg(follow_pkg::reg_zone_min, 32'd4);
  write_reg(follow_pkg::reg_status, 32'hffff_ffff);  // read only
  check_reg(follow_pkg::reg_status, 32'h0);
  check_reg(4'd12, 32'h0);
endtask

task automatic centred_forward();
  int c [6] = '{90, 70, 40, 10, 145, 160};  // magnitudes 0..3, then too close
  write_reg(follow_pkg::reg_ctrl, 32'd1);
  write_reg(follow_pkg::reg_area_target, 32'd200);
  write_reg(follow_pkg::reg_area_step, 32'd50);
  for (int k = 0; k < 6; k++) begin
    zone_hits = '{0, 0, 0, c[k], c[k], 0, 0, 0};
    frame_and_check(1'b0);
  end
endtask

task automatic off_centre_turns();
  int z2 [4] = '{0, 2, 6, 4};  // one zone per vel step
  for (int z = 0; z < 8; z++) begin
    zone_hits = '{default: 0};
    zone_hits[z] = 30;
    frame_and_check(1'b0);
  end
  write_reg(follow_pkg::reg_vel0, 32'd11);
  write_reg(follow_pkg::reg_vel1, 32'd222);
  write_reg(follow_pkg::reg_vel2, 32'h0000_ffdf);  // -33, reversing turn
  write_reg(follow_pkg::reg_vel3, 32'd1000);
  for (int k = 0; k < 4; k++) begin
    zone_hits = '{default: 0};
    zone_hits[z2[k]] = 12;
    frame_and_check(1'b0);
  end
endtask

task automatic random_status();
  for (int k = 0; k < 6; k++) begin
    write_reg(follow_pkg::reg_zone_min, rand_bits(4) + 1);
    for (int z = 0; z < 8; z++) zone_hits[z] = rand_bits(5);
    frame_and_check(1'b0);
  end
  write_reg(follow_pkg::reg_zone_min, 32'd4);
endtask

task automatic lost_timeout();
  write_reg(follow_pkg::reg_lost_limit, 32'd300);
  zone_hits = '{default: 0};
  frame_and_check(1'b1);  // empty frame runs past the limit
  zone_hits = '{0, 0, 0, 60, 60, 0, 0, 0};
  frame_and_check(1'b0);
  write_reg(follow_pkg::reg_lost_limit, 32'h4000_0000);
endtask

task automatic disable_stops();
  zone_hits = '{0, 0, 25, 0, 0, 0, 0, 0};
  frame_and_check(1'b0);
  write_reg(follow_pkg::reg_ctrl, 32'd0);
  model_speeds(1'b0);
  wait_speeds();
  frame_and_check(1'b0);  // object still seen, wheels stay still
endtask

// File: dv/follow_tb.sv
`timescale 1ns/1ns

module follow_tb;

  localparam int img_width = 160;
  localparam int zone_w = img_width / 8;

  logic                  clk;
  logic                  rst;
  logic                  cfg_we;
  follow_pkg::cfg_addr_t cfg_addr;
  follow_pkg::cfg_data_t cfg_wdata;
  follow_pkg::cfg_data_t cfg_rdata;
  logic                  pix_valid;
  logic                  pix_hit;
  logic                  line_end;
  logic                  frame_end;
  follow_pkg::speed_t    motor_dps_left;
  follow_pkg::speed_t    motor_dps_rght;

  logic [31:0] lfsr;
  int          zone_hits [8];           // hits per zone for the next frame
  logic        hit_map [8][img_width];  // zone, line * zone_w + column

  // shadow of the register block
  logic               sh_enable;
  logic [15:0]        sh_zone_min;
  logic [15:0]        sh_area_target;
  logic [15:0]        sh_area_step;
  logic signed [15:0] sh_vel [4];

  // expected stored centroid and wheel speeds
  logic [7:0]         exp_cent;
  logic [2:0]         exp_prox;
  logic signed [15:0] exp_left;
  logic signed [15:0] exp_rght;

  follow_top #(
    .img_width (img_width)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .cfg_we         (cfg_we),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .cfg_rdata      (cfg_rdata),
    .pix_valid      (pix_valid),
    .pix_hit        (pix_hit),
    .line_end       (line_end),
    .frame_end      (frame_end),
    .motor_dps_left (motor_dps_left),
    .motor_dps_rght (motor_dps_rght)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | rand_bit();
    end
    return v;
  endfunction

  task automatic write_reg(input follow_pkg::cfg_addr_t a, input logic [31:0] d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we = 1'b0;
    case (a)
      follow_pkg::reg_ctrl:        sh_enable      = d[0];
      follow_pkg::reg_zone_min:    sh_zone_min    = d[15:0];
      follow_pkg::reg_area_target: sh_area_target = d[15:0];
      follow_pkg::reg_area_step:   sh_area_step   = d[15:0];
      follow_pkg::reg_vel0:        sh_vel[0]      = d[15:0];
      follow_pkg::reg_vel1:        sh_vel[1]      = d[15:0];
      follow_pkg::reg_vel2:        sh_vel[2]      = d[15:0];
      follow_pkg::reg_vel3:        sh_vel[3]      = d[15:0];
      default: ;
    endcase
  endtask

  // readback is combinational, sampled away from the clock edge
  task automatic read_reg(input follow_pkg::cfg_addr_t a, output logic [31:0] d);
    @(negedge clk);
    cfg_we   = 1'b0;
    cfg_addr = a;
    #1;
    d = cfg_rdata;
  endtask

  // 8 lines, each zone's hits scattered over its slots
  task automatic send_frame();
    int rem;
    logic h;
    for (int z = 0; z < 8; z++) begin
      rem = zone_hits[z];
      for (int s = 0; s < img_width; s++) begin
        if (rem == 0) begin
          h = 1'b0;
        end else if (rem >= img_width - s) begin
          h = 1'b1;  // must fill every remaining slot
        end else begin
          h = rand_bit();
        end
        hit_map[z][s] = h;
        if (h) rem--;
      end
    end
    for (int ln = 0; ln < 8; ln++) begin
      for (int c = 0; c < img_width; c++) begin
        @(negedge clk);
        pix_valid = 1'b1;
        pix_hit   = hit_map[c / zone_w][ln * zone_w + c % zone_w];
      end
      @(negedge clk);
      pix_valid = 1'b0;
      pix_hit   = 1'b0;
      line_end  = 1'b1;
      @(negedge clk);
      line_end = 1'b0;
    end
    frame_end = 1'b1;
    @(negedge clk);
    frame_end = 1'b0;
  endtask

  `include "follow_tests.svh"

  initial begin
    lfsr      = 32'hfe37fbd0;
    rst       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    pix_valid = 1'b0;
    pix_hit   = 1'b0;
    line_end  = 1'b0;
    frame_end = 1'b0;
    sh_enable      = 1'b0;
    sh_zone_min    = 16'd4;
    sh_area_target = 16'd400;
    sh_area_step   = 16'd100;
    sh_vel[0]      = 16'sd25;
    sh_vel[1]      = 16'sd50;
    sh_vel[2]      = 16'sd100;
    sh_vel[3]      = 16'sd200;
    exp_cent       = '0;
    exp_prox       = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_values();
    centred_forward();
    off_centre_turns();
    random_status();
    lost_timeout();
    disable_stops();

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: hw/follow_top.sv
`timescale 1ns/1ns

module follow_top #(
  parameter int img_width = 160  // multiple of 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_we,
  input  follow_pkg::cfg_addr_t cfg_addr,
  input  follow_pkg::cfg_data_t cfg_wdata,
  output follow_pkg::cfg_data_t cfg_rdata,
  input  logic                  pix_valid,
  input  logic                  pix_hit,
  input  logic                  line_end,
  input  logic                  frame_end,
  output follow_pkg::speed_t    motor_dps_left,
  output follow_pkg::speed_t    motor_dps_rght
);

  // configuration
  logic                    enable;
  follow_pkg::pix_count_t  zone_min;
  follow_pkg::pix_count_t  area_target;
  follow_pkg::pix_count_t  area_step;
  follow_pkg::speed_t      vel0;
  follow_pkg::speed_t      vel1;
  follow_pkg::speed_t      vel2;
  follow_pkg::speed_t      vel3;
  follow_pkg::lost_count_t lost_limit;

  // frame result
  follow_pkg::zone_mask_t  centroid;
  follow_pkg::prox_t       proximity;
  logic                    new_centroid;
  logic                    lost;

  tracker_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .centroid     (centroid),
    .proximity    (proximity),
    .new_centroid (new_centroid),
    .lost         (lost),
    .enable       (enable),
    .zone_min     (zone_min),
    .area_target  (area_target),
    .area_step    (area_step),
    .vel0         (vel0),
    .vel1         (vel1),
    .vel2         (vel2),
    .vel3         (vel3),
    .lost_limit   (lost_limit)
  );

  object_locator #(
    .img_width (img_width)
  ) u_locator (
    .clk          (clk),
    .rst          (rst),
    .pix_valid    (pix_valid),
    .pix_hit      (pix_hit),
    .line_end     (line_end),
    .frame_end    (frame_end),
    .zone_min     (zone_min),
    .area_target  (area_target),
    .area_step    (area_step),
    .centroid     (centroid),
    .proximity    (proximity),
    .new_centroid (new_centroid)
  );

  motor_speed_ctrl u_speed (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .centroid       (centroid),
    .proximity      (proximity),
    .new_centroid   (new_centroid),
    .vel0           (vel0),
    .vel1           (vel1),
    .vel2           (vel2),
    .vel3           (vel3),
    .lost_limit     (lost_limit),
    .motor_dps_left (motor_dps_left),
    .motor_dps_rght (motor_dps_rght),
    .lost           (lost)
  );

endmodule

// File: hw/motor_speed_ctrl.sv
`timescale 1ns/1ns

module motor_speed_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  follow_pkg::zone_mask_t  centroid,
  input  follow_pkg::prox_t       proximity,
  input  logic                    new_centroid,
  input  follow_pkg::speed_t      vel0,
  input  follow_pkg::speed_t      vel1,
  input  follow_pkg::speed_t      vel2,
  input  follow_pkg::speed_t      vel3,
  input  follow_pkg::lost_count_t lost_limit,
  output follow_pkg::speed_t      motor_dps_left,
  output follow_pkg::speed_t      motor_dps_rght,
  output logic                    lost
);

  follow_pkg::zone_mask_t  last_cent;  // last nonzero centroid
  follow_pkg::prox_t       last_prox;
  follow_pkg::lost_count_t lost_cnt;
  logic                    store;

  follow_pkg::speed_t mag_speed;   // centred, by proximity magnitude
  follow_pkg::speed_t fwd_speed;
  follow_pkg::speed_t obj_left_spd;  // right wheel when object is on the left
  follow_pkg::speed_t obj_rght_spd;  // left wheel when object is on the right
  follow_pkg::speed_t left_nxt;
  follow_pkg::speed_t rght_nxt;

  assign store = new_centroid && (centroid != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      last_cent <= '0;
      last_prox <= '0;
    end else if (store) begin
      last_cent <= centroid;
      last_prox <= proximity;
    end
  end

  // lost timeout
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      lost_cnt <= '0;
      lost     <= 1'b0;
    end else begin
      if (store) begin
        lost_cnt <= '0;
      end else if (lost_cnt != '1) begin
        lost_cnt <= lost_cnt + 1'b1;
      end
      lost <= (lost_cnt > lost_limit);
    end
  end

  always_comb begin
    case (last_prox[1:0])
      2'd1:    mag_speed = vel1;
      2'd2:    mag_speed = vel2;
      2'd3:    mag_speed = vel3;
      default: mag_speed = '0;  // on target, hold still
    endcase
    fwd_speed = last_prox[2] ? -mag_speed : mag_speed;  // too close backs off

    // further from centre turns harder
    if (last_cent[3]) begin
      obj_left_spd = vel0;
    end else if (last_cent[2]) begin
      obj_left_spd = vel1;
    end else if (last_cent[1]) begin
      obj_left_spd = vel2;
    end else begin
      obj_left_spd = vel3;
    end

    if (last_cent[4]) begin
      obj_rght_spd = vel0;
    end else if (last_cent[5]) begin
      obj_rght_spd = vel1;
    end else if (last_cent[6]) begin
      obj_rght_spd = vel2;
    end else begin
      obj_rght_spd = vel3;
    end
  end

  always_comb begin
    if (!enable || lost || last_cent == '0) begin
      left_nxt = '0;
      rght_nxt = '0;
    end else if (last_cent[4] && last_cent[3]) begin
      left_nxt = fwd_speed;
      rght_nxt = fwd_speed;
    end else if (|last_cent[3:0]) begin
      left_nxt = '0;  // pivot left on the right wheel
      rght_nxt = obj_left_spd;
    end else begin
      left_nxt = obj_rght_spd;
      rght_nxt = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      motor_dps_left <= '0;
      motor_dps_rght <= '0;
    end else begin
      motor_dps_left <= left_nxt;
      motor_dps_rght <= rght_nxt;
    end
  end

endmodule

// File: hw/object_locator.sv
`timescale 1ns/1ns

module object_locator #(
  parameter int img_width = 160
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   pix_valid,
  input  logic                   pix_hit,
  input  logic                   line_end,
  input  logic                   frame_end,
  input  follow_pkg::pix_count_t zone_min,
  input  follow_pkg::pix_count_t area_target,
  input  follow_pkg::pix_count_t area_step,
  output follow_pkg::zone_mask_t centroid,
  output follow_pkg::prox_t      proximity,
  output logic                   new_centroid
);

  localparam int zone_w = img_width / 8;
  localparam int col_w  = (zone_w > 1) ? $clog2(zone_w) : 1;
  localparam logic [col_w-1:0] col_last = col_w'(zone_w - 1);

  logic [col_w-1:0] zone_col;  // column inside the current zone
  logic [2:0]       zone_idx;

  follow_pkg::pix_count_t zone_cnt [8];
  follow_pkg::pix_count_t total_cnt;

  // frame result, ahead of the output register
  follow_pkg::zone_mask_t mask_nxt;
  follow_pkg::prox_t      prox_nxt;
  follow_pkg::pix_count_t area_diff;
  logic                   too_close;
  logic [1:0]             mag;

  // step thresholds, two spare bits so 3x never wraps
  logic [17:0] step1;
  logic [17:0] step2;
  logic [17:0] step3;

  // counts stick at all ones
  function automatic follow_pkg::pix_count_t sat_inc(input follow_pkg::pix_count_t v);
    sat_inc = (v == '1) ? v : v + 1'b1;
  endfunction

  // column position, cleared on every line
  always_ff @(posedge clk) begin
    if (rst || line_end || frame_end) begin
      zone_col <= '0;
      zone_idx <= '0;
    end else if (pix_valid) begin
      if (zone_col == col_last) begin
        zone_col <= '0;
        if (zone_idx != 3'd7) begin
          zone_idx <= zone_idx + 3'd1;  // overlong lines pile into the last zone
        end
      end else begin
        zone_col <= zone_col + 1'b1;
      end
    end
  end

  // hit accumulation over one frame
  always_ff @(posedge clk) begin
    if (rst || frame_end) begin
      for (int i = 0; i < 8; i++) begin
        zone_cnt[i] <= '0;
      end
      total_cnt <= '0;
    end else if (pix_valid && pix_hit) begin
      zone_cnt[zone_idx] <= sat_inc(zone_cnt[zone_idx]);
      total_cnt          <= sat_inc(total_cnt);
    end
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      mask_nxt[i] = (zone_cnt[i] >= zone_min);
    end
  end

  // distance from the target area, in steps
  always_comb begin
    too_close = (total_cnt > area_target);
    if (too_close) begin
      area_diff = total_cnt - area_target;
    end else begin
      area_diff = area_target - total_cnt;
    end

    step1 = {2'b00, area_step};
    step2 = step1 << 1;
    step3 = step2 + step1;

    if (area_diff < step1) begin
      mag = 2'd0;
    end else if (area_diff < step2) begin
      mag = 2'd1;
    end else if (area_diff < step3) begin
      mag = 2'd2;
    end else begin
      mag = 2'd3;  // far off, full step
    end

    prox_nxt = {too_close, mag};
  end

  // result register, valid with the pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      centroid     <= '0;
      proximity    <= '0;
      new_centroid <= 1'b0;
    end else begin
      new_centroid <= frame_end;
      if (frame_end) begin
        centroid  <= mask_nxt;
        proximity <= prox_nxt;
      end
    end
  end

endmodule

// File: hw/tracker_regs.sv
`timescale 1ns/1ns

module tracker_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cfg_we,
  input  follow_pkg::cfg_addr_t   cfg_addr,
  input  follow_pkg::cfg_data_t   cfg_wdata,
  output follow_pkg::cfg_data_t   cfg_rdata,
  input  follow_pkg::zone_mask_t  centroid,
  input  follow_pkg::prox_t       proximity,
  input  logic                    new_centroid,
  input  logic                    lost,
  output logic                    enable,
  output follow_pkg::pix_count_t  zone_min,
  output follow_pkg::pix_count_t  area_target,
  output follow_pkg::pix_count_t  area_step,
  output follow_pkg::speed_t      vel0,
  output follow_pkg::speed_t      vel1,
  output follow_pkg::speed_t      vel2,
  output follow_pkg::speed_t      vel3,
  output follow_pkg::lost_count_t lost_limit
);

  // result of the last finished frame
  follow_pkg::zone_mask_t stat_mask;
  follow_pkg::prox_t      stat_prox;

  // writable configuration
  always_ff @(posedge clk) begin
    if (rst) begin
      enable      <= follow_pkg::enable_rst;
      zone_min    <= follow_pkg::zone_min_rst;
      area_target <= follow_pkg::area_target_rst;
      area_step   <= follow_pkg::area_step_rst;
      vel0        <= follow_pkg::vel0_rst;
      vel1        <= follow_pkg::vel1_rst;
      vel2        <= follow_pkg::vel2_rst;
      vel3        <= follow_pkg::vel3_rst;
      lost_limit  <= follow_pkg::lost_limit_rst;
    end else if (cfg_we) begin
      case (cfg_addr)
        follow_pkg::reg_ctrl:        enable      <= cfg_wdata[0];
        follow_pkg::reg_zone_min:    zone_min    <= cfg_wdata[15:0];
        follow_pkg::reg_area_target: area_target <= cfg_wdata[15:0];
        follow_pkg::reg_area_step:   area_step   <= cfg_wdata[15:0];
        follow_pkg::reg_vel0:        vel0        <= cfg_wdata[15:0];
        follow_pkg::reg_vel1:        vel1        <= cfg_wdata[15:0];
        follow_pkg::reg_vel2:        vel2        <= cfg_wdata[15:0];
        follow_pkg::reg_vel3:        vel3        <= cfg_wdata[15:0];
        follow_pkg::reg_lost_limit:  lost_limit  <= cfg_wdata;
        default: ;  // status is read only
      endcase
    end
  end

  // status capture, once per frame
  always_ff @(posedge clk) begin
    if (rst) begin
      stat_mask <= '0;
      stat_prox <= '0;
    end else if (new_centroid) begin
      stat_mask <= centroid;
      stat_prox <= proximity;
    end
  end

  // readback mux
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      follow_pkg::reg_ctrl:        cfg_rdata = {31'h0, enable};
      follow_pkg::reg_zone_min:    cfg_rdata = {16'h0, zone_min};
      follow_pkg::reg_area_target: cfg_rdata = {16'h0, area_target};
      follow_pkg::reg_area_step:   cfg_rdata = {16'h0, area_step};
      follow_pkg::reg_vel0:        cfg_rdata = {16'h0, vel0};
      follow_pkg::reg_vel1:        cfg_rdata = {16'h0, vel1};
      follow_pkg::reg_vel2:        cfg_rdata = {16'h0, vel2};
      follow_pkg::reg_vel3:        cfg_rdata = {16'h0, vel3};
      follow_pkg::reg_lost_limit:  cfg_rdata = lost_limit;
      follow_pkg::reg_status: begin
        cfg_rdata[7:0]  = stat_mask;
        cfg_rdata[10:8] = stat_prox;
        cfg_rdata[16]   = lost;  // live, not captured
      end
      default:                     cfg_rdata = '0;
    endcase
  end

endmodule

// File: hw/follow_pkg.sv
package follow_pkg;

  // zone mask, bit 0 is the leftmost column zone
  typedef logic [7:0] zone_mask_t;

  // [2] too close, [1:0] distance magnitude
  typedef logic [2:0] prox_t;

  typedef logic signed [15:0] speed_t;  // wheel speed in deg/s
  typedef logic [15:0] pix_count_t;     // pixel counts and area settings
  typedef logic [31:0] lost_count_t;
  typedef logic [3:0] cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // register map
  localparam cfg_addr_t reg_ctrl        = 4'd0;  // [0] enable
  localparam cfg_addr_t reg_zone_min    = 4'd1;
  localparam cfg_addr_t reg_area_target = 4'd2;
  localparam cfg_addr_t reg_area_step   = 4'd3;
  localparam cfg_addr_t reg_vel0        = 4'd4;
  localparam cfg_addr_t reg_vel1        = 4'd5;
  localparam cfg_addr_t reg_vel2        = 4'd6;
  localparam cfg_addr_t reg_vel3        = 4'd7;
  localparam cfg_addr_t reg_lost_limit  = 4'd8;
  localparam cfg_addr_t reg_status      = 4'd9;  // read only

  // reset values
  localparam logic        enable_rst      = 1'b0;
  localparam pix_count_t  zone_min_rst    = 16'd4;
  localparam pix_count_t  area_target_rst = 16'd400;
  localparam pix_count_t  area_step_rst   = 16'd100;

  // speed steps, slowest first
  localparam speed_t      vel0_rst        = 16'sd25;
  localparam speed_t      vel1_rst        = 16'sd50;
  localparam speed_t      vel2_rst        = 16'sd100;
  localparam speed_t      vel3_rst        = 16'sd200;

  localparam lost_count_t lost_limit_rst  = 32'h4000_0000;

endpackage
